// ==== src.f ====
logic/scope_pkg.sv
logic/scope_regs.sv
logic/scope_dec_avg.sv
logic/scope_edge.sv
logic/scope_acq.sv
logic/scope_top.sv
sim/tb_scope_top.sv

// ==== Makefile ====
# build and run the testbench, the result comes from the printed pass line

TOP := tb_scope_top

sim:
	verilator --binary --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) | awk '{print} /Everything OK/{ok=1} END{exit !ok}'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== sim/tb_scope_top.sv ====
`timescale 1ns/1ps

module tb_scope_top;

  import scope_pkg::*;

  logic          bus;
  logic          reset;
  logic          wb_cyc, wb_stb, wb_we, wb_ack;
  wb_adr_t       wb_adr;
  wb_data_t      wb_wdata, wb_rdata;
  scope_stream_t sti, sto;
  logic          sti_ready, sto_ready;
  ext_t          evn_ext;

  integer   seed = 71;
  int       errors, tests, err_before;
  sample_t  src[0:255];
  // one entry per decimated group
  sample_t  exp_data[0:255];
  int       exp_n, rx_cnt, last_cnt;
  bit       chk_en, bp_en;
  wb_data_t rd;
  // programmed config mirror for the reference model
  int       c_dec, c_shr, c_pre, c_pst;
  bit       c_avg, c_aut, c_edg_en;
  sample_t  c_pos, c_neg;

  scope_top i_dut (
    .bus, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
    .sti, .sti_ready, .sto, .sto_ready, .evn_ext
  );

  initial bus = 1'b0;
  always #50 bus = ~bus;

  //////////////////////////////////////////////////
  // checks and reference model
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  // expected record from the sent samples
  // returns the record length or 0 when none completes
  function automatic int ref_record(input int n_in);
    int      ng, trg;
    longint  sum;
    bit      armed, hit;
    sample_t v;
    ng    = n_in / c_dec;
    trg   = -1;
    armed = 1'b0;
    for (int g = 0; g < ng; g++) begin
      sum = 0;
      for (int k = 0; k < c_dec; k++) sum += longint'(src[g*c_dec+k]);
      // average truncates to sample width after the shift
      v = c_avg ? sample_t'(sum >>> c_shr) : src[g*c_dec+c_dec-1];
      exp_data[g] = v;
      // rising schmitt rule
      hit = armed && (v >= c_pos);
      if (hit) armed = 1'b0;
      else if (v < c_neg) armed = 1'b1;
      // trigger only once pre samples are in
      if (trg < 0 && g >= c_pre && (c_aut || (c_edg_en && hit))) trg = g;
    end
    if (trg < 0 || trg + c_pst + 1 > ng) return 0;
    return trg + c_pst + 1;
  endfunction

  // one compare per sto transfer
  always @(posedge bus) begin
    if (!reset && sto.valid && sto_ready) begin
      if (chk_en && rx_cnt < exp_n) begin
        check_value("sto.data", int'(exp_data[rx_cnt]), int'(sto.data));
        check_value("sto.last", int'(rx_cnt == exp_n - 1), int'(sto.last));
      end else if (chk_en) begin
        $display("sample received after the end of the record at %0t ns", $time);
        errors++;
      end
      rx_cnt++;
      if (sto.last) last_cnt++;
    end
  end

  // random back-pressure
  always @(posedge bus) begin
    sto_ready <= bp_en ? (($random(seed) & 1) != 0) : 1'b1;
  end

  //////////////////////////////////////////////////
  // bus and stream tasks
  //////////////////////////////////////////////////

  task automatic wb_access(input bit we, input wb_adr_t adr, input wb_data_t data);
    int t;
    t = 0;
    @(posedge bus);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_wdata <= data;
    // hold the request until ack
    do begin
      @(posedge bus);
      t++;
    end while (!wb_ack && t < 50);
    if (!wb_ack) begin
      $display("no wishbone ack at address %0h", adr);
      errors++;
    end
    rd = wb_rdata;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
    wb_access(1'b1, adr, data);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
    wb_access(1'b0, adr, '0);
    data = rd;
  endtask

  task automatic check_reg(input wb_adr_t adr, input string name, input wb_data_t expected);
    wb_data_t data;
    wb_read(adr, data);
    check_value(name, int'(expected), int'(data));
  endtask

  // clear the path and program all config registers
  task automatic configure(input bit aut, input bit edg_en, input int mask,
                           input int pre, input int pst, input int dec,
                           input int shr, input bit avg);
    c_aut    = aut;
    c_edg_en = edg_en;
    c_pre    = pre;
    c_pst    = pst;
    c_dec    = dec;
    c_shr    = shr;
    c_avg    = avg;
    wb_write(REG_CTL, 32'h1);
    wb_write(REG_MODE, {30'b0, aut, 1'b0});
    wb_write(REG_MASK, wb_data_t'(mask) | {11'b0, edg_en, 20'b0});
    wb_write(REG_PRE, wb_data_t'(pre));
    wb_write(REG_PST, wb_data_t'(pst));
    wb_write(REG_POS, {16'b0, c_pos});
    wb_write(REG_NEG, {16'b0, c_neg});
    wb_write(REG_EDG, 32'h0);
    wb_write(REG_DEC, wb_data_t'(dec));
    wb_write(REG_SHR, wb_data_t'(shr));
    wb_write(REG_AVG, {31'b0, avg});
    rx_cnt   = 0;
    last_cnt = 0;
  endtask

  // source with random valid gaps
  task automatic send_samples(input int n);
    int i, t;
    i = 0;
    t = 0;
    while (i < n && t < 5000) begin
      @(posedge bus);
      t++;
      if (sti.valid && sti_ready) i++;
      if (i < n && ($random(seed) & 3) != 0) begin
        sti.valid <= 1'b1;
        sti.data  <= src[i];
      end else begin
        sti.valid <= 1'b0;
      end
    end
    if (i < n) begin
      $display("source stalled after %0d of %0d samples", i, n);
      errors++;
    end
    sti.valid <= 1'b0;
  endtask

  task automatic wait_last();
    int t;
    t = 0;
    while (last_cnt == 0 && t < 3000) begin
      @(posedge bus);
      t++;
    end
    if (last_cnt == 0) begin
      $display("record never ended with last");
      errors++;
    end
  endtask

  // one cycle pulse on the event lines
  task automatic pulse_event(input ext_t ev);
    @(posedge bus);
    evn_ext <= ev;
    @(posedge bus);
    evn_ext <= '0;
  endtask

  task automatic fill(input bit rnd, input int n);
    for (int i = 0; i < n; i++)
      src[i] = rnd ? sample_t'($random(seed)) : sample_t'(i * 37 - 2000);
  endtask

  task automatic capture(input bit ext_start, input int n);
    exp_n = ref_record(n);
    if (exp_n == 0) begin
      $display("reference found no complete record");
      errors++;
    end
    chk_en = 1'b1;
    if (ext_start) begin
      pulse_event(4'h4);
    end else begin
      wb_write(REG_CTL, 32'h2);
    end
    send_samples(n);
    wait_last();
    check_value("record length", exp_n, rx_cnt);
    check_value("last count", 1, last_cnt);
  endtask

  task automatic report(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    err_before = errors;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    {wb_cyc, wb_stb, wb_we} = '0;
    wb_adr = '0;
    wb_wdata = '0;
    sti = '0;
    sto_ready = 1'b1;
    evn_ext = '0;
    {errors, tests, err_before, exp_n, rx_cnt, last_cnt} = '0;
    {chk_en, bp_en} = '0;
    repeat (8) @(posedge bus);
    reset <= 1'b0;

    // register readback masked to field widths
    wb_write(REG_MODE, 32'hffff_ffff);
    wb_write(REG_MASK, 32'hffff_ffff);
    wb_write(REG_PRE, 32'h1234_5678);
    wb_write(REG_PST, 32'h9abc_def0);
    wb_write(REG_POS, 32'hffff_8001);
    wb_write(REG_NEG, 32'h0000_7ffe);
    wb_write(REG_EDG, 32'hffff_ffff);
    wb_write(REG_DEC, 32'hffff_ffff);
    wb_write(REG_SHR, 32'hffff_ffff);
    wb_write(REG_AVG, 32'hffff_ffff);
    check_reg(REG_MODE, "REG_MODE", 32'h3);
    check_reg(REG_MASK, "REG_MASK", 32'h1f_0f0f);
    check_reg(REG_PRE, "REG_PRE", 32'h1234_5678);
    check_reg(REG_PST, "REG_PST", 32'h9abc_def0);
    check_reg(REG_POS, "REG_POS", 32'h8001);
    check_reg(REG_NEG, "REG_NEG", 32'h7ffe);
    check_reg(REG_EDG, "REG_EDG", 32'h1);
    check_reg(REG_DEC, "REG_DEC", 32'h1_ffff);
    check_reg(REG_SHR, "REG_SHR", 32'hf);
    check_reg(REG_AVG, "REG_AVG", 32'h1);
    check_reg(7'h0c, "unmapped 0x0c", 32'h0);
    check_reg(7'h20, "unmapped 0x20", 32'h0);
    report("register readback");

    // plain decimation with auto trigger
    c_pos = 16'sd8000;
    c_neg = -16'sd8000;
    configure(1'b1, 1'b0, 0, 3, 4, 4, 0, 1'b0);
    fill(1'b0, 48);
    capture(1'b0, 48);
    check_reg(REG_STS_PRE, "sts_pre", 32'd3);
    check_reg(REG_STS_PST, "sts_pst", 32'd4);
    // triggered and back to idle
    check_reg(REG_CTL, "REG_CTL status", 32'h8);
    report("decimation");

    // block average of 4 with shift 2
    configure(1'b1, 1'b0, 0, 2, 5, 4, 2, 1'b1);
    fill(1'b1, 64);
    capture(1'b0, 64);
    report("averaging");

    // rising level trigger
    configure(1'b0, 1'b1, 0, 5, 6, 2, 0, 1'b0);
    fill(1'b1, 160);
    capture(1'b0, 160);
    report("level trigger");

    // external start under random back-pressure
    bp_en = 1'b1;
    configure(1'b1, 1'b0, 32'h0804, 4, 5, 3, 0, 1'b0);
    fill(1'b1, 90);
    capture(1'b1, 90);
    bp_en = 1'b0;

    // masked stop while waiting for a trigger
    configure(1'b0, 1'b0, 32'h0804, 4, 5, 1, 0, 1'b0);
    chk_en = 1'b0;
    fill(1'b0, 20);
    pulse_event(4'h4);
    send_samples(20);
    // running, not yet triggered
    check_reg(REG_CTL, "REG_CTL while waiting", 32'h2);
    pulse_event(4'h8);
    repeat (4) @(posedge bus);
    check_reg(REG_CTL, "REG_CTL after stop", 32'h0);
    // pre and wait samples all forwarded
    check_value("samples before stop", 20, rx_cnt);
    // a late trigger must not restart the record
    wb_write(REG_CTL, 32'h8);
    send_samples(20);
    repeat (8) @(posedge bus);
    check_value("samples after stop", 20, rx_cnt);
    check_value("last after stop", 0, last_cnt);
    report("external start/stop");

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== logic/scope_top.sv ====
`timescale 1ns/1ps

module scope_top (
  input  logic                     bus,
  input  logic                     reset,
  // wishbone classic
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  scope_pkg::wb_adr_t       wb_adr,
  input  scope_pkg::wb_data_t      wb_wdata,
  output scope_pkg::wb_data_t      wb_rdata,
  output logic                     wb_ack,
  // sample streams
  input  scope_pkg::scope_stream_t sti,
  output logic                     sti_ready,
  output scope_pkg::scope_stream_t sto,
  input  logic                     sto_ready,
  // external events
  input  scope_pkg::ext_t          evn_ext
);

  import scope_pkg::*;

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  scope_cfg_t    cfg;
  logic          ctl_rst, sw_str, sw_stp, sw_trg;
  cnt_t          sts_pre, sts_pst;
  logic          sts_run, sts_trg;
  // decimator to edge, edge to acquisition
  scope_stream_t dec, edg;
  logic          dec_ready, edg_ready;
  logic          edg_hit;

  scope_regs i_regs (
    .bus, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
    .cfg, .ctl_rst, .sw_str, .sw_stp, .sw_trg,
    .sts_pre, .sts_pst, .sts_run, .sts_trg
  );

  scope_dec_avg i_dec_avg (
    .bus, .reset, .ctl_rst, .cfg,
    .sti, .sti_ready, .sto (dec), .sto_ready (dec_ready)
  );

  scope_edge i_edge (
    .bus, .reset, .ctl_rst, .cfg,
    .sti (dec), .sti_ready (dec_ready), .sto (edg), .sto_ready (edg_ready), .edg_hit
  );

  scope_acq i_acq (
    .bus, .reset, .ctl_rst, .cfg,
    .sti (edg), .sti_ready (edg_ready), .sto, .sto_ready,
    .edg_hit, .evn_ext, .sw_str, .sw_stp, .sw_trg,
    .sts_pre, .sts_pst, .sts_run, .sts_trg
  );

endmodule

// ==== logic/scope_acq.sv ====
`timescale 1ns/1ps

module scope_acq (
  input  logic                   bus,
  input  logic                   reset,
  input  logic                   ctl_rst,
  input  scope_pkg::scope_cfg_t  cfg,
  // stream in/out
  input  scope_pkg::scope_stream_t sti,
  output logic                   sti_ready,
  output scope_pkg::scope_stream_t sto,
  input  logic                   sto_ready,
  // events
  input  logic                   edg_hit,
  input  scope_pkg::ext_t        evn_ext,
  input  logic                   sw_str,
  input  logic                   sw_stp,
  input  logic                   sw_trg,
  // status
  output scope_pkg::cnt_t        sts_pre,
  output scope_pkg::cnt_t        sts_pst,
  output logic                   sts_run,
  output logic                   sts_trg
);

  import scope_pkg::*;

  acq_state_t state;
  acq_state_t start_state;
  logic       acc, fwd, lst, rec_done;
  logic       ev_str, ev_stp, ev_trg, trg_pend, trg_hit;
  logic       pre_done, pst_done;
  logic       out_valid, out_last;
  sample_t    out_data;

  // idle drops input so upstream never stalls
  assign sti_ready = (state == IDLE) | ~out_valid | sto_ready;
  assign acc       = sti.valid & sti_ready;

  //////////////////////////////////////////////////
  // events and record framing
  //////////////////////////////////////////////////

  assign ev_str  = sw_str | (|(evn_ext & cfg.str_mask));
  assign ev_stp  = sw_stp | (|(evn_ext & cfg.stp_mask));
  assign ev_trg  = sw_trg | (|(evn_ext & cfg.trg_mask));
  // trigger always lands on an accepted sample
  assign trg_hit = cfg.aut | trg_pend | ev_trg | (cfg.edg_en & edg_hit);

  assign pre_done    = (sts_pre + cnt_t'(1)) >= cfg.pre;
  assign pst_done    = (sts_pst + cnt_t'(1)) >= cfg.pst;
  // no pre samples, straight to wait
  assign start_state = (cfg.pre == '0) ? WAIT : PRE;

  assign fwd = (state != IDLE) & ~ev_stp;
  assign lst = ((state == WAIT) & trg_hit & (cfg.pst == '0)) | ((state == POST) & pst_done);
  assign rec_done = acc & fwd & lst;

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      state <= IDLE;
      {sts_pre, sts_pst} <= '0;
      {sts_trg, trg_pend, out_valid, out_last} <= '0;
    end else begin
      if (acc && fwd) begin
        out_valid <= 1'b1;
        out_last  <= lst;
      end else if (sto_ready) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end
      if (state == IDLE) begin
        if (ev_str) begin
          state <= start_state;
          {sts_pre, sts_pst} <= '0;
          {sts_trg, trg_pend} <= '0;
        end
      end else if (ev_stp) begin
        // abort, no last sent
        state    <= IDLE;
        trg_pend <= 1'b0;
      end else begin
        case (state)
          PRE: if (acc) begin
            sts_pre <= sts_pre + cnt_t'(1);
            if (pre_done) state <= WAIT;
          end
          WAIT: if (acc && trg_hit) begin
            state    <= POST;
            sts_trg  <= 1'b1;
            trg_pend <= 1'b0;
          end else if (ev_trg) begin
            trg_pend <= 1'b1;
          end
          POST: if (acc) sts_pst <= sts_pst + cnt_t'(1);
          default: state <= IDLE;
        endcase
        // end of record overrides the step above
        if (rec_done) begin
          state <= cfg.con ? start_state : IDLE;
          if (cfg.con) begin
            {sts_pre, sts_pst} <= '0;
            sts_trg <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge bus) begin
    if (acc && fwd) out_data <= sti.data;
  end

  assign sts_run = state != IDLE;
  assign sto     = '{valid: out_valid, last: out_last, data: out_data};

endmodule

// ==== logic/scope_edge.sv ====
`timescale 1ns/1ps

module scope_edge (
  input  logic                   bus,
  input  logic                   reset,
  input  logic                   ctl_rst,
  input  scope_pkg::scope_cfg_t  cfg,
  // stream monitor
  input  scope_pkg::scope_stream_t sti,
  output logic                   sti_ready,
  output scope_pkg::scope_stream_t sto,
  input  logic                   sto_ready,
  // trigger, travels with sto
  output logic                   edg_hit
);

  import scope_pkg::*;

  logic    acc;
  logic    arm_c;
  logic    fire_c;
  logic    armed;
  logic    hit;
  logic    out_valid;
  logic    out_last;
  sample_t out_data;

  assign sti_ready = ~out_valid | sto_ready;
  assign acc       = sti.valid & sti_ready;

  //////////////////////////////////////////////////
  // schmitt trigger
  //////////////////////////////////////////////////

  // falling mode mirrors rising
  always_comb begin
    if (cfg.edg) begin
      arm_c  = sti.data > cfg.pos;
      fire_c = sti.data <= cfg.neg;
    end else begin
      arm_c  = sti.data < cfg.neg;
      fire_c = sti.data >= cfg.pos;
    end
  end

  assign hit = armed & fire_c;

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      armed     <= 1'b0;
      out_valid <= 1'b0;
      edg_hit   <= 1'b0;
    end else if (acc) begin
      out_valid <= 1'b1;
      edg_hit   <= hit;
      // firing disarms, rearm needs the opposite level again
      if (hit) begin
        armed <= 1'b0;
      end else if (arm_c) begin
        armed <= 1'b1;
      end
    end else if (sto_ready) begin
      out_valid <= 1'b0;
      edg_hit   <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (acc) begin
      out_data <= sti.data;
      out_last <= sti.last;
    end
  end

  assign sto = '{valid: out_valid, last: out_last, data: out_data};

endmodule

// ==== logic/scope_dec_avg.sv ====
`timescale 1ns/1ps

module scope_dec_avg (
  input  logic                   bus,
  input  logic                   reset,
  input  logic                   ctl_rst,
  input  scope_pkg::scope_cfg_t  cfg,
  // input stream
  input  scope_pkg::scope_stream_t sti,
  output logic                   sti_ready,
  // decimated stream
  output scope_pkg::scope_stream_t sto,
  input  logic                   sto_ready
);

  import scope_pkg::*;

  logic    acc;
  logic    done;
  dec_t    cnt_q;
  dec_t    grp_end;
  sum_t    sum_q;
  sum_t    sum_d;
  sum_t    sum_shr;
  logic    out_valid;
  logic    out_last;
  sample_t out_data;

  // output register empty or draining
  assign sti_ready = ~out_valid | sto_ready;
  assign acc       = sti.valid & sti_ready;

  // index of the last sample in a group, dec 0 acts as 1
  assign grp_end = (cfg.dec == '0) ? '0 : cfg.dec - dec_t'(1);
  // >= so a smaller dec written mid group still closes it
  assign done    = cnt_q >= grp_end;

  //////////////////////////////////////////////////
  // block sum and shift
  //////////////////////////////////////////////////

  assign sum_d   = sum_q + sum_t'(sti.data);
  assign sum_shr = sum_d >>> cfg.shr;

  always_ff @(posedge bus) begin
    if (reset || ctl_rst) begin
      cnt_q     <= '0;
      sum_q     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (acc) begin
        if (done) begin
          cnt_q <= '0;
          sum_q <= '0;
        end else begin
          cnt_q <= cnt_q + dec_t'(1);
          sum_q <= sum_d;
        end
      end
      // one output per completed group
      if (acc && done) begin
        out_valid <= 1'b1;
      end else if (sto_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // payload, average is truncated to sample width
  always_ff @(posedge bus) begin
    if (acc && done) begin
      out_data <= cfg.avg ? $signed(sum_shr[SAMPLE_W-1:0]) : sti.data;
      out_last <= sti.last;
    end
  end

  assign sto = '{valid: out_valid, last: out_last, data: out_data};

endmodule

// ==== logic/scope_regs.sv ====
`timescale 1ns/1ps

module scope_regs (
  input  logic                 bus,
  input  logic                 reset,
  // wishbone classic slave
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  scope_pkg::wb_adr_t   wb_adr,
  input  scope_pkg::wb_data_t  wb_wdata,
  output scope_pkg::wb_data_t  wb_rdata,
  output logic                 wb_ack,
  // configuration and control pulses
  output scope_pkg::scope_cfg_t cfg,
  output logic                 ctl_rst,
  output logic                 sw_str,
  output logic                 sw_stp,
  output logic                 sw_trg,
  // acquisition status
  input  scope_pkg::cnt_t      sts_pre,
  input  scope_pkg::cnt_t      sts_pst,
  input  logic                 sts_run,
  input  logic                 sts_trg
);

  import scope_pkg::*;

  logic     req;
  logic     wr;
  logic     rd;
  wb_data_t rd_word;

  //////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////

  // new request only while ack is low, so a held cycle is acked once
  assign req = wb_cyc & wb_stb & ~wb_ack;
  assign wr  = req & wb_we;
  assign rd  = req & ~wb_we;

  always_ff @(posedge bus) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      cfg <= '0;
    end else if (wr) begin
      case (wb_adr)
        REG_MODE: begin
          cfg.con <= wb_wdata[0];
          cfg.aut <= wb_wdata[1];
        end
        REG_MASK: begin
          cfg.str_mask <= wb_wdata[0 +: EXT_W];
          cfg.stp_mask <= wb_wdata[8 +: EXT_W];
          cfg.trg_mask <= wb_wdata[16 +: EXT_W];
          cfg.edg_en   <= wb_wdata[20];
        end
        REG_PRE: cfg.pre <= wb_wdata[CNT_W-1:0];
        REG_PST: cfg.pst <= wb_wdata[CNT_W-1:0];
        REG_POS: cfg.pos <= wb_wdata[SAMPLE_W-1:0];
        REG_NEG: cfg.neg <= wb_wdata[SAMPLE_W-1:0];
        REG_EDG: cfg.edg <= wb_wdata[0];
        REG_DEC: cfg.dec <= wb_wdata[DEC_W-1:0];
        REG_SHR: cfg.shr <= wb_wdata[SHR_W-1:0];
        REG_AVG: cfg.avg <= wb_wdata[0];
        default: ;
      endcase
    end
  end

  // ctl register bits 0..3, reset start stop trigger
  always_ff @(posedge bus) begin
    if (reset) begin
      {sw_trg, sw_stp, sw_str, ctl_rst} <= '0;
    end else if (wr && wb_adr == REG_CTL) begin
      {sw_trg, sw_stp, sw_str, ctl_rst} <= wb_wdata[3:0];
    end else begin
      {sw_trg, sw_stp, sw_str, ctl_rst} <= '0;
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    case (wb_adr)
      REG_CTL:     rd_word = wb_data_t'({sts_trg, 1'b0, sts_run, 1'b0});
      REG_MODE:    rd_word = wb_data_t'({cfg.aut, cfg.con});
      REG_MASK:    rd_word = wb_data_t'({cfg.edg_en, cfg.trg_mask, 4'b0,
                                         cfg.stp_mask, 4'b0, cfg.str_mask});
      REG_PRE:     rd_word = wb_data_t'(cfg.pre);
      REG_PST:     rd_word = wb_data_t'(cfg.pst);
      REG_STS_PRE: rd_word = wb_data_t'(sts_pre);
      REG_STS_PST: rd_word = wb_data_t'(sts_pst);
      // levels come back zero extended
      REG_POS:     rd_word = {{(WB_W-SAMPLE_W){1'b0}}, cfg.pos};
      REG_NEG:     rd_word = {{(WB_W-SAMPLE_W){1'b0}}, cfg.neg};
      REG_EDG:     rd_word = wb_data_t'(cfg.edg);
      REG_DEC:     rd_word = wb_data_t'(cfg.dec);
      REG_SHR:     rd_word = wb_data_t'(cfg.shr);
      REG_AVG:     rd_word = wb_data_t'(cfg.avg);
      default:     rd_word = '0;
    endcase
  end

  // captured with the request, valid in the ack cycle
  always_ff @(posedge bus) begin
    if (rd) begin
      wb_rdata <= rd_word;
    end
  end

endmodule

// ==== logic/scope_pkg.sv ====
package scope_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int SAMPLE_W = 16;
  localparam int CNT_W    = 32;
  localparam int DEC_W    = 17;
  localparam int SHR_W    = 4;
  localparam int EXT_W    = 4;
  localparam int ADR_W    = 7;
  localparam int WB_W     = 32;
  // block sum needs room for a full group of samples
  localparam int SUM_W    = SAMPLE_W + DEC_W;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [CNT_W-1:0]    cnt_t;
  typedef logic        [DEC_W-1:0]    dec_t;
  typedef logic        [SHR_W-1:0]    shr_t;
  typedef logic        [EXT_W-1:0]    ext_t;
  typedef logic        [WB_W-1:0]     wb_data_t;
  typedef logic        [ADR_W-1:0]    wb_adr_t;
  typedef logic signed [SUM_W-1:0]    sum_t;

  //////////////////////////////////////////////////
  // register map, byte offsets
  //////////////////////////////////////////////////

  localparam wb_adr_t REG_CTL     = 7'h00;
  localparam wb_adr_t REG_MODE    = 7'h04;
  localparam wb_adr_t REG_MASK    = 7'h08;
  localparam wb_adr_t REG_PRE     = 7'h10;
  localparam wb_adr_t REG_PST     = 7'h14;
  localparam wb_adr_t REG_STS_PRE = 7'h18;
  localparam wb_adr_t REG_STS_PST = 7'h1c;
  localparam wb_adr_t REG_POS     = 7'h40;
  localparam wb_adr_t REG_NEG     = 7'h44;
  localparam wb_adr_t REG_EDG     = 7'h48;
  localparam wb_adr_t REG_DEC     = 7'h50;
  localparam wb_adr_t REG_SHR     = 7'h54;
  localparam wb_adr_t REG_AVG     = 7'h58;

  //////////////////////////////////////////////////
  // streams, config and acquisition state
  //////////////////////////////////////////////////

  typedef struct packed {
    logic    valid;
    logic    last;
    sample_t data;
  } scope_stream_t;

  typedef struct packed {
    // mode
    logic    con;
    logic    aut;
    // event masks
    ext_t    str_mask;
    ext_t    stp_mask;
    ext_t    trg_mask;
    logic    edg_en;
    // pre/post trigger lengths
    cnt_t    pre;
    cnt_t    pst;
    // schmitt levels, edge 0 rising 1 falling
    sample_t pos;
    sample_t neg;
    logic    edg;
    // decimation
    dec_t    dec;
    shr_t    shr;
    logic    avg;
  } scope_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    PRE,
    WAIT,
    POST
  } acq_state_t;

endpackage
